// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = video_pattern_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
PASS_MSG  = TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: rtl/color_bar_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "video_config.svh"

module color_bar_gen (
    input  logic                  clk,
    input  logic                  reset,
    input  video_pkg::pixel_pos_t pos,
    output video_pkg::rgb444_t    bar_rgb
);

    import video_pkg::*;

    // Colour constants.
    localparam logic [3:0] C0 = 4'h0;
    localparam logic [3:0] CF = 4'hF;

    localparam logic [11:0] COL_BLACK  = {C0, C0, C0};
    localparam logic [11:0] COL_RED    = {CF, C0, C0};
    localparam logic [11:0] COL_GREEN  = {C0, CF, C0};
    localparam logic [11:0] COL_BLUE   = {C0, C0, CF};
    localparam logic [11:0] COL_YELLOW = {CF, CF, C0};
    localparam logic [11:0] COL_CYAN   = {C0, CF, CF};
    localparam logic [11:0] COL_MAG    = {CF, C0, CF};
    localparam logic [11:0] COL_WHITE  = {CF, CF, CF};

    // ================================================
    // Bar and band geometry.
    // ================================================
    localparam int unsigned BAR_W   = `H_ACTIVE / `BAR_NUM;
    localparam int unsigned WIDE_W  = BAR_W * 5 / 4;
    localparam int unsigned STEP_W  = BAR_W / 3;
    localparam int unsigned STEP_X0 = BAR_W * 5;
    localparam int unsigned Y_TOP   = `V_ACTIVE * 2 / 3;
    localparam int unsigned Y_MID   = `V_ACTIVE * 8 / 11;

    logic [31:0] px;
    logic [31:0] py;
    logic [11:0] rgb_next;

    assign px = 32'(pos.x);
    assign py = 32'(pos.y);

    always_comb begin
        rgb_next = COL_BLACK;
        if (pos.de) begin
            if (py < Y_TOP) begin
                if      (px < BAR_W * 1) rgb_next = COL_WHITE;
                else if (px < BAR_W * 2) rgb_next = COL_YELLOW;
                else if (px < BAR_W * 3) rgb_next = COL_CYAN;
                else if (px < BAR_W * 4) rgb_next = COL_GREEN;
                else if (px < BAR_W * 5) rgb_next = COL_MAG;
                else if (px < BAR_W * 6) rgb_next = COL_RED;
                else if (px < BAR_W * 7) rgb_next = COL_BLUE;
            end else if (py < Y_MID) begin
                if      (px < BAR_W * 1) rgb_next = COL_BLUE;
                else if (px < BAR_W * 3 && px >= BAR_W * 2) rgb_next = COL_MAG;
                else if (px < BAR_W * 5 && px >= BAR_W * 4) rgb_next = COL_CYAN;
                else if (px < BAR_W * 7 && px >= BAR_W * 6) rgb_next = COL_WHITE;
            end else begin
                // Wide bars, then a short grey ramp.
                if      (px < WIDE_W * 1)             rgb_next = 12'h009;
                else if (px < WIDE_W * 2)             rgb_next = COL_WHITE;
                else if (px < WIDE_W * 3)             rgb_next = 12'h70C;
                else if (px < STEP_X0)                rgb_next = COL_BLACK;
                else if (px < STEP_X0 + STEP_W * 1)   rgb_next = 12'h111;
                else if (px < STEP_X0 + STEP_W * 2)   rgb_next = 12'h222;
                else if (px < STEP_X0 + STEP_W * 3)   rgb_next = 12'h333;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bar_rgb.word <= COL_BLACK;
        end else begin
            bar_rgb.word <= rgb_next;
        end
    end

endmodule

`default_nettype wire

// File: rtl/grid_overlay_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "video_config.svh"

module grid_overlay_gen (
    input  logic                  clk,
    input  logic                  reset,
    input  video_pkg::pixel_pos_t pos,
    output video_pkg::overlay_t   ovl
);

    import video_pkg::*;

    localparam int unsigned X_LAST = `H_ACTIVE - 1;
    localparam int unsigned Y_LAST = `V_ACTIVE - 1;
    localparam int unsigned STEP   = `GRID_STEP;

    localparam logic [11:0] COL_WHITE = 12'hFFF;
    localparam logic [11:0] COL_BLACK = 12'h000;

    logic [31:0] px;
    logic [31:0] py;
    logic        on_border;
    logic        on_grid;
    logic        hit_next;

    assign px = 32'(pos.x);
    assign py = 32'(pos.y);

    // ================================================
    // Line detection.
    // ================================================
    assign on_border = (px == 0) || (px == X_LAST) || (py == 0) || (py == Y_LAST);
    assign on_grid   = ((px % STEP) == 0) || ((py % STEP) == 0);
    assign hit_next  = pos.de && (on_border || on_grid);

    always_ff @(posedge clk) begin
        if (reset) begin
            ovl.hit        <= 1'b0;
            ovl.color.word <= COL_BLACK;
        end else begin
            ovl.hit        <= hit_next;
            ovl.color.word <= hit_next ? COL_WHITE : COL_BLACK;
        end
    end

    a_hit_only_active: assert property (
        @(posedge clk) disable iff (reset)
        !pos.de |=> !ovl.hit
    ) else $error("overlay hit outside active area");

endmodule

`default_nettype wire

// File: rtl/pixel_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_mixer (
    input  logic                     clk,
    input  logic                     reset,
    input  video_pkg::rgb444_t       bar_rgb,
    input  video_pkg::overlay_t      ovl,
    input  logic                     de_in,
    input  logic                     hsync_raw,
    input  logic                     vsync_raw,
    input  video_pkg::pattern_mode_t mode,
    output logic [3:0]               vga_r,
    output logic [3:0]               vga_g,
    output logic [3:0]               vga_b,
    output logic                     hsync,
    output logic                     vsync,
    output logic                     de
);

    import video_pkg::*;

    localparam rgb444_t BLACK = '0;

    rgb444_t mix_rgb;
    rgb444_t pix_q;
    logic    de_d1;
    logic    hsync_d1;
    logic    vsync_d1;

    // ================================================
    // Pattern select.
    // ================================================
    always_comb begin
        mix_rgb = bar_rgb;
        case (mode)
            MODE_BARS:      mix_rgb = bar_rgb;
            MODE_BARS_GRID: mix_rgb = ovl.hit ? ovl.color : bar_rgb;
            MODE_GRID_ONLY: mix_rgb = ovl.hit ? ovl.color : BLACK;
            MODE_INV_GRID: begin
                if (ovl.hit) begin
                    mix_rgb = ovl.color;
                end else begin
                    mix_rgb.ch.r = 4'hF - bar_rgb.ch.r;
                    mix_rgb.ch.g = 4'hF - bar_rgb.ch.g;
                    mix_rgb.ch.b = 4'hF - bar_rgb.ch.b;
                end
            end
            default:        mix_rgb = bar_rgb;
        endcase
    end

    // First stage matches the generator latency.
    always_ff @(posedge clk) begin
        if (reset) begin
            de_d1    <= 1'b0;
            hsync_d1 <= 1'b1;
            vsync_d1 <= 1'b1;
            pix_q    <= BLACK;
            de       <= 1'b0;
            hsync    <= 1'b1;
            vsync    <= 1'b1;
        end else begin
            de_d1    <= de_in;
            hsync_d1 <= hsync_raw;
            vsync_d1 <= vsync_raw;
            pix_q    <= de_d1 ? mix_rgb : BLACK;
            de       <= de_d1;
            hsync    <= hsync_d1;
            vsync    <= vsync_d1;
        end
    end

    assign vga_r = pix_q.ch.r;
    assign vga_g = pix_q.ch.g;
    assign vga_b = pix_q.ch.b;

    a_blank_when_idle: assert property (
        @(posedge clk) !de |-> (vga_r == 4'h0 && vga_g == 4'h0 && vga_b == 4'h0)
    ) else $error("nonzero RGB while de is low");

endmodule

`default_nettype wire

// File: rtl/vga_timing.sv
`timescale 1ns/1ps
`default_nettype none

`include "video_config.svh"

module vga_timing (
    input  logic                  clk,
    input  logic                  reset,
    output video_pkg::pixel_pos_t pos,
    output logic                  hsync_raw,
    output logic                  vsync_raw
);

    import video_pkg::*;

    localparam int W = `COORD_W;

    localparam logic [W-1:0] H_LAST   = W'(`H_TOTAL - 1);
    localparam logic [W-1:0] V_LAST   = W'(`V_TOTAL - 1);
    localparam logic [W-1:0] H_VIS    = W'(`H_ACTIVE);
    localparam logic [W-1:0] V_VIS    = W'(`V_ACTIVE);
    localparam logic [W-1:0] HS_START = W'(`H_ACTIVE + `H_FRONT);
    localparam logic [W-1:0] HS_END   = W'(`H_ACTIVE + `H_FRONT + `H_SYNC);
    localparam logic [W-1:0] VS_START = W'(`V_ACTIVE + `V_FRONT);
    localparam logic [W-1:0] VS_END   = W'(`V_ACTIVE + `V_FRONT + `V_SYNC);

    logic [W-1:0] h_cnt;
    logic [W-1:0] v_cnt;
    logic [W-1:0] h_next;
    logic [W-1:0] v_next;
    logic         de_q;
    logic         de_next;
    logic         hs_next;
    logic         vs_next;

    // ================================================
    // Next counter state.
    // ================================================
    always_comb begin
        h_next = (h_cnt == H_LAST) ? '0 : h_cnt + 1'b1;
        v_next = v_cnt;
        if (h_cnt == H_LAST) begin
            v_next = (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
        end
    end

    // Sync pulses are active low.
    assign de_next = (h_next < H_VIS) && (v_next < V_VIS);
    assign hs_next = !((h_next >= HS_START) && (h_next < HS_END));
    assign vs_next = !((v_next >= VS_START) && (v_next < VS_END));

    always_ff @(posedge clk) begin
        if (reset) begin
            h_cnt     <= '0;
            v_cnt     <= '0;
            // Position 0,0 is visible.
            de_q      <= 1'b1;
            hsync_raw <= 1'b1;
            vsync_raw <= 1'b1;
        end else begin
            h_cnt     <= h_next;
            v_cnt     <= v_next;
            de_q      <= de_next;
            hsync_raw <= hs_next;
            vsync_raw <= vs_next;
        end
    end

    assign pos = '{x: h_cnt, y: v_cnt, de: de_q};

    a_de_outside_sync: assert property (
        @(posedge clk) disable iff (reset)
        pos.de |-> (hsync_raw && vsync_raw)
    ) else $error("de high during sync pulse");

endmodule

`default_nettype wire

// File: rtl/video_config.svh
`ifndef VIDEO_CONFIG_SVH
`define VIDEO_CONFIG_SVH

// ================================================
// Horizontal raster, in pixel clocks.
// ================================================
`define H_ACTIVE 640
`define H_FRONT  16
`define H_SYNC   96
`define H_BACK   48
`define H_TOTAL  (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)

// ================================================
// Vertical raster, in lines.
// ================================================
`define V_ACTIVE 480
`define V_FRONT  10
`define V_SYNC   2
`define V_BACK   33
`define V_TOTAL  (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)

// Width of the x and y counters.
`define COORD_W 10

// ================================================
// Pattern geometry.
// ================================================
// Number of colour bars across the screen.
`define BAR_NUM 7

// Grid line spacing, same in both directions.
`define GRID_STEP 64

`endif

// File: rtl/video_pattern_top.sv
`timescale 1ns/1ps
`default_nettype none

module video_pattern_top (
    input  logic                     clk,
    input  logic                     reset,
    input  video_pkg::pattern_mode_t mode,
    output logic [3:0]               vga_r,
    output logic [3:0]               vga_g,
    output logic [3:0]               vga_b,
    output logic                     hsync,
    output logic                     vsync,
    output logic                     de
);

    import video_pkg::*;

    pixel_pos_t pos;
    logic       hsync_raw;
    logic       vsync_raw;
    rgb444_t    bar_rgb;
    overlay_t   ovl;

    vga_timing u_timing (
        .clk       (clk),
        .reset     (reset),
        .pos       (pos),
        .hsync_raw (hsync_raw),
        .vsync_raw (vsync_raw)
    );

    // Both generators see the same position.
    color_bar_gen u_bars (
        .clk     (clk),
        .reset   (reset),
        .pos     (pos),
        .bar_rgb (bar_rgb)
    );

    grid_overlay_gen u_grid (
        .clk   (clk),
        .reset (reset),
        .pos   (pos),
        .ovl   (ovl)
    );

    pixel_mixer u_mixer (
        .clk       (clk),
        .reset     (reset),
        .bar_rgb   (bar_rgb),
        .ovl       (ovl),
        .de_in     (pos.de),
        .hsync_raw (hsync_raw),
        .vsync_raw (vsync_raw),
        .mode      (mode),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b),
        .hsync     (hsync),
        .vsync     (vsync),
        .de        (de)
    );

endmodule

`default_nettype wire

// File: rtl/video_pkg.sv
`default_nettype none

`include "video_config.svh"

package video_pkg;

    // Raster position of one pixel.
    typedef struct packed {
        logic [`COORD_W-1:0] x;
        logic [`COORD_W-1:0] y;
        logic                de;
    } pixel_pos_t;

    // RGB444 word, red in the top nibble.
    typedef union packed {
        logic [11:0] word;
        struct packed {
            logic [3:0] r;
            logic [3:0] g;
            logic [3:0] b;
        } ch;
    } rgb444_t;

    // Overlay result for one pixel.
    typedef struct packed {
        logic    hit;
        rgb444_t color;
    } overlay_t;

    // ================================================
    // Output pattern selection.
    // ================================================
    typedef enum logic [1:0] {
        MODE_BARS      = 2'd0,
        MODE_BARS_GRID = 2'd1,
        MODE_GRID_ONLY = 2'd2,
        MODE_INV_GRID  = 2'd3
    } pattern_mode_t;

endpackage

`default_nettype wire

// File: verification/video_pattern_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "video_config.svh"

module video_pattern_tb;

    import video_pkg::*;

    localparam int RUN_CYCLES     = 2 * `H_TOTAL * `V_TOTAL;
    // Two frames plus 75 lines of slack.
    localparam int TIMEOUT_CYCLES = RUN_CYCLES + 75 * `H_TOTAL;
    localparam int BAR_W          = `H_ACTIVE / `BAR_NUM;
    localparam int WIDE_W         = BAR_W * 5 / 4;
    localparam int RAMP_X         = 5 * BAR_W;

    // Bar colours per index. The last entry pads the line.
    localparam logic [11:0] TOP_BARS [8] = '{12'hFFF, 12'hFF0, 12'h0FF, 12'h0F0,
                                            12'hF0F, 12'hF00, 12'h00F, 12'h000};
    localparam logic [11:0] MID_BARS [8] = '{12'h00F, 12'h000, 12'hF0F, 12'h000,
                                            12'h0FF, 12'h000, 12'hFFF, 12'h000};

    logic          clk;
    logic          reset;
    pattern_mode_t mode;
    pattern_mode_t applied_mode;
    logic [3:0]    vga_r;
    logic [3:0]    vga_g;
    logic [3:0]    vga_b;
    logic          hsync;
    logic          vsync;
    logic          de;
    logic [15:0]   lfsr_state;
    logic [1:0]    mode_bits;
    int            de_low_run  = 0;
    int            error_count = 0;
    int            pixel_count = 0;
    int            line_count  = 0;
    int            frame_count = 0;
    int            cycle_count = 0;
    int            now         = 0;
    int            x_pos       = 0;
    int            y_pos       = 0;
    int            hs_fall_at  = -1;
    int            vs_fall_at  = -1;
    logic          de_prev     = 1'b0;
    logic          hs_prev     = 1'b1;
    logic          vs_prev     = 1'b1;

    video_pattern_top video_pattern_top_inst (
        .clk   (clk),
        .reset (reset),
        .mode  (mode),
        .vga_r (vga_r),
        .vga_g (vga_g),
        .vga_b (vga_b),
        .hsync (hsync),
        .vsync (vsync),
        .de    (de)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Mode seen by the mixer register on each rising edge.
    always @(posedge clk) applied_mode <= mode;

    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    // ==================================================
    // Expected pixel from position and mode.
    // ==================================================
    function automatic logic [11:0] reference_rgb(input int x, input int y,
                                                  input pattern_mode_t m);
        logic [11:0] bar;
        logic [11:0] result;
        logic        grid;
        bar = 12'h000;
        if (y < `V_ACTIVE * 2 / 3) begin
            bar = TOP_BARS[3'(x / BAR_W)];
        end else if (y < `V_ACTIVE * 8 / 11) begin
            bar = MID_BARS[3'(x / BAR_W)];
        end else if (x < 3 * WIDE_W) begin
            bar = (x < WIDE_W) ? 12'h009 : (x < 2 * WIDE_W) ? 12'hFFF : 12'h70C;
        end else if (x >= RAMP_X && x < RAMP_X + 3 * (BAR_W / 3)) begin
            // Grey steps 111, 222, 333.
            bar = {3{4'(1 + (x - RAMP_X) / (BAR_W / 3))}};
        end
        grid = (x % `GRID_STEP == 0) || (y % `GRID_STEP == 0)
            || (x == `H_ACTIVE - 1) || (y == `V_ACTIVE - 1);
        case (m)
            MODE_BARS:      result = bar;
            MODE_BARS_GRID: result = grid ? 12'hFFF : bar;
            MODE_GRID_ONLY: result = grid ? 12'hFFF : 12'h000;
            default: begin
                result = grid ? 12'hFFF
                              : {4'hF - bar[11:8], 4'hF - bar[7:4], 4'hF - bar[3:0]};
            end
        endcase
        return result;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        end
    endtask

    // ==================================================
    // Stimulus and run control.
    // ==================================================
    initial begin
        reset      = 1'b1;
        mode       = MODE_BARS;
        lfsr_state = 16'd11;
        mode_bits  = 2'b00;
        repeat (2) begin
            @(negedge clk);
            check_value("reset outputs", 32'h3000, 32'({de, hsync, vsync, vga_r, vga_g, vga_b}));
        end
        reset = 1'b0;
        @(negedge clk);
        check_value("post-reset outputs", 32'h3000,
                    32'({de, hsync, vsync, vga_r, vga_g, vga_b}));
        repeat (RUN_CYCLES) begin
            @(negedge clk);
            de_low_run = de ? 0 : de_low_run + 1;
            // New mode once per line inside horizontal blanking.
            if (de_low_run == 4) begin
                lfsr_state   = lfsr_step(lfsr_state);
                mode_bits[0] = lfsr_state[0];
                lfsr_state   = lfsr_step(lfsr_state);
                mode_bits[1] = lfsr_state[0];
                mode         = pattern_mode_t'(mode_bits);
            end
        end
        @(posedge clk);
        check_value("frames seen", 2, frame_count);
        check_value("active lines seen", 2 * `V_ACTIVE, line_count);
        check_value("active pixels seen", 2 * `H_ACTIVE * `V_ACTIVE, pixel_count);
        $display("Errors: %0d, pixels: %0d, lines: %0d, frames: %0d",
                 error_count, pixel_count, line_count, frame_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // ==================================================
    // Output monitor and compare.
    // ==================================================
    initial begin
        @(negedge reset);
        forever begin
            @(negedge clk);
            now++;
            if (de) begin
                check_value($sformatf("pixel x=%0d y=%0d mode=%0d", x_pos, y_pos, applied_mode),
                            32'(reference_rgb(x_pos, y_pos, applied_mode)),
                            32'({vga_r, vga_g, vga_b}));
                pixel_count++;
                x_pos++;
            end else begin
                check_value("blanking rgb", 32'h0, 32'({vga_r, vga_g, vga_b}));
            end
            // Line starts after the sync pulse and back porch.
            if (de && !de_prev && hs_fall_at >= 0) begin
                check_value("hsync to de", `H_SYNC + `H_BACK, now - hs_fall_at);
            end
            if (de_prev && !de) begin
                check_value($sformatf("active width y=%0d", y_pos), `H_ACTIVE, x_pos);
                x_pos = 0;
                y_pos++;
                line_count++;
            end
            if (hsync && !hs_prev) check_value("hsync width", `H_SYNC, now - hs_fall_at);
            if (!hsync && hs_prev) begin
                if (hs_fall_at >= 0) check_value("line period", `H_TOTAL, now - hs_fall_at);
                hs_fall_at = now;
            end
            if (vsync && !vs_prev) begin
                check_value("vsync width", `V_SYNC * `H_TOTAL, now - vs_fall_at);
            end
            if (!vsync && vs_prev) begin
                check_value("active lines in frame", `V_ACTIVE, y_pos);
                check_value("hsync to vsync", `H_SYNC + `H_BACK, now - hs_fall_at);
                x_pos = 0;
                y_pos = 0;
                vs_fall_at = now;
                frame_count++;
            end
            de_prev = de;
            hs_prev = hsync;
            vs_prev = vsync;
        end
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+rtl
rtl/video_pkg.sv
rtl/vga_timing.sv
rtl/color_bar_gen.sv
rtl/grid_overlay_gen.sv
rtl/pixel_mixer.sv
rtl/video_pattern_top.sv
verification/video_pattern_tb.sv
